// File: logic/nlc_pkg.sv
// Q15.16 signed fixed point; samples above +-2^15 wrap once moved into Q15.16
`default_nettype none

package nlc_pkg;

	localparam int NUM_CH   = 16;
	localparam int CH_W     = $clog2(NUM_CH);
	localparam int ADC_W    = 21;
	localparam int WORD_W   = 32;
	localparam int PROD_W   = 2 * WORD_W;
	localparam int FRAC_W   = 16;
	localparam int ORDER    = 5;
	localparam int NUM_PASS = ORDER + 1;  // Pass 0 normalizes, 1..5 are Horner steps
	localparam int PASS_W   = $clog2(NUM_PASS);
	localparam int MAC_LAT  = 2;
	localparam int DRN_W    = $clog2(MAC_LAT + 1);

	// Word address is channel * FIELDS_PER_CH + field
	localparam int FIELDS_PER_CH = 8;
	localparam int FLD_W         = $clog2(FIELDS_PER_CH);
	localparam int ADR_W         = CH_W + FLD_W;
	localparam int FLD_OFFSET    = 0;
	localparam int FLD_RECIP     = 1;
	localparam int FLD_COEF0     = 2;  // coeff0..coeff5 in fields 2..7

	localparam int NLC_LATENCY = NUM_PASS * (NUM_CH + MAC_LAT + 1) + 2;

	typedef logic signed [ADC_W-1:0]  adc_word_t;
	typedef logic signed [WORD_W-1:0] nlc_word_t;

	typedef struct packed {
		nlc_word_t           offset;  // Pre-scaled by recip_stdev
		nlc_word_t           recip_stdev;
		nlc_word_t [ORDER:0] coeff;
	} nlc_chan_params_t;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		DRAIN,
		RELEASE
	} nlc_state_t;

endpackage

`default_nettype wire

// File: logic/nlc_mac_if.sv
// No stall path, the multiply-add pipe takes one operation every cycle
`default_nettype none

interface nlc_mac_if;
	import nlc_pkg::*;

	logic            op_valid;
	nlc_word_t       op_a;
	nlc_word_t       op_b;
	nlc_word_t       op_c;
	logic [CH_W-1:0] op_tag;  // Channel of the operation

	logic            res_valid;
	nlc_word_t       res;
	logic [CH_W-1:0] res_tag;

	modport issuer (
		output op_valid, op_a, op_b, op_c, op_tag
	);

	modport mac (
		input  op_valid, op_a, op_b, op_c, op_tag,
		output res_valid, res, res_tag
	);

	modport sink (
		input res_valid, res, res_tag
	);

endinterface

`default_nettype wire

// File: logic/nlc_param_bank.sv
// Wishbone classic slave, one wait state; writes stall while busy_i is high, reads never stall
`default_nettype none

module nlc_param_bank (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            wb_cyc_i,
	input  wire                            wb_stb_i,
	input  wire                            wb_we_i,
	input  wire [nlc_pkg::ADR_W-1:0]       wb_adr_i,
	input  wire nlc_pkg::nlc_word_t        wb_dat_i,
	output nlc_pkg::nlc_word_t             wb_dat_o,
	output logic                           wb_ack_o,
	input  wire                            busy_i,
	input  wire [nlc_pkg::CH_W-1:0]        rd_ch_i,
	output nlc_pkg::nlc_chan_params_t      params_o
);
	import nlc_pkg::*;

	nlc_word_t        mem_q [NUM_CH][FIELDS_PER_CH];
	logic [CH_W-1:0]  adr_ch;
	logic [FLD_W-1:0] adr_fld;
	logic             req;
	logic             req_ok;

	assign adr_ch  = wb_adr_i[ADR_W-1:FLD_W];
	assign adr_fld = wb_adr_i[FLD_W-1:0];

	// New request only while no ack is out
	assign req    = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign req_ok = req && !(wb_we_i && busy_i);  // Hold writes in wait states during a run

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= req_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (req_ok) begin
			if (wb_we_i) begin
				mem_q[adr_ch][adr_fld] <= wb_dat_i;
			end
			wb_dat_o <= mem_q[adr_ch][adr_fld];
		end
	end

	// Row for the channel the datapath is working on
	always_comb begin
		params_o.offset      = mem_q[rd_ch_i][FLD_OFFSET];
		params_o.recip_stdev = mem_q[rd_ch_i][FLD_RECIP];
		for (int i = 0; i <= ORDER; i++) begin
			params_o.coeff[i] = mem_q[rd_ch_i][FLD_COEF0 + i];
		end
	end

endmodule

`default_nettype wire

// File: logic/nlc_seq_fsm.sv
// start_i is only honoured in IDLE; done_o pulses one cycle after RELEASE as busy_o drops
`default_nettype none

module nlc_seq_fsm (
	input  wire  clk,
	input  wire  reset,
	input  wire  start_i,
	input  wire  ch_last_i,
	input  wire  pass_last_i,
	input  wire  drain_done_i,
	output logic capture_o,
	output logic count_clr_o,
	output logic issue_en_o,
	output logic release_o,
	output logic busy_o,
	output logic done_o
);
	import nlc_pkg::*;

	nlc_state_t state_q;
	nlc_state_t state_d;
	logic       accept;

	assign accept      = (state_q == IDLE) && start_i;
	assign capture_o   = accept;
	assign count_clr_o = accept;
	assign issue_en_o  = (state_q == ISSUE);
	assign release_o   = (state_q == RELEASE);
	assign busy_o      = (state_q != IDLE);

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (accept) begin
					state_d = ISSUE;
				end
			end
			ISSUE: begin
				if (ch_last_i) begin
					state_d = DRAIN;  // Last channel of this pass issued
				end
			end
			DRAIN: begin
				if (drain_done_i) begin
					state_d = pass_last_i ? RELEASE : ISSUE;
				end
			end
			RELEASE: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= IDLE;
			done_o  <= 1'b0;
		end else begin
			state_q <= state_d;
			done_o  <= release_o;  // Lines up with the x_lin_o update
		end
	end

endmodule

`default_nettype wire

// File: logic/nlc_step_counter.sv
// Drain runs MAC_LAT + 1 cycles after the last channel; pass index wraps after the last pass
`default_nettype none

module nlc_step_counter (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        clr_i,
	input  wire                        issue_en_i,
	output logic [nlc_pkg::CH_W-1:0]   ch_idx_o,
	output logic [nlc_pkg::PASS_W-1:0] pass_idx_o,
	output logic                       ch_last_o,
	output logic                       pass_last_o,
	output logic                       drain_done_o
);
	import nlc_pkg::*;

	logic [DRN_W-1:0] drn_cnt_q;
	logic             draining_q;

	assign ch_last_o    = (ch_idx_o == CH_W'(NUM_CH - 1));
	assign pass_last_o  = (pass_idx_o == PASS_W'(NUM_PASS - 1));
	assign drain_done_o = draining_q && (drn_cnt_q == DRN_W'(MAC_LAT));

	always_ff @(posedge clk) begin
		if (reset || clr_i) begin
			ch_idx_o   <= '0;
			pass_idx_o <= '0;
			drn_cnt_q  <= '0;
			draining_q <= 1'b0;
		end else begin
			if (issue_en_i) begin
				ch_idx_o <= ch_last_o ? '0 : ch_idx_o + 1'b1;
			end
			if (issue_en_i && ch_last_o) begin
				draining_q <= 1'b1;  // Channel index wrapped
				drn_cnt_q  <= '0;
			end else if (drain_done_o) begin
				draining_q <= 1'b0;
				drn_cnt_q  <= '0;
				pass_idx_o <= pass_last_o ? '0 : pass_idx_o + 1'b1;
			end else if (draining_q) begin
				drn_cnt_q <= drn_cnt_q + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/nlc_mac_pipe.sv
// res = ((a * b) >>> FRAC_W) + c, wrapped to WORD_W bits; two register stages, no stall
`default_nettype none

module nlc_mac_pipe (
	input wire     clk,
	input wire     reset,
	nlc_mac_if.mac mac
);
	import nlc_pkg::*;

	logic                     v1_q;
	logic signed [PROD_W-1:0] prod_q;
	nlc_word_t                c1_q;
	logic [CH_W-1:0]          tag1_q;
	logic signed [PROD_W-1:0] sum;

	// Stage 1, full product
	always_ff @(posedge clk) begin
		if (reset) begin
			v1_q <= 1'b0;
		end else begin
			v1_q <= mac.op_valid;
		end
	end

	always_ff @(posedge clk) begin
		prod_q <= mac.op_a * mac.op_b;
		c1_q   <= mac.op_c;
		tag1_q <= mac.op_tag;
	end

	assign sum = (prod_q >>> FRAC_W) + c1_q;  // Arithmetic shift keeps the sign

	// Stage 2, rescale and add
	always_ff @(posedge clk) begin
		if (reset) begin
			mac.res_valid <= 1'b0;
		end else begin
			mac.res_valid <= v1_q;
		end
	end

	always_ff @(posedge clk) begin
		mac.res     <= sum[WORD_W-1:0];
		mac.res_tag <= tag1_q;
	end

endmodule

`default_nettype wire

// File: logic/nlc_operand_store.sv
// Operands leave through a register; all results of a pass land before the next pass reads them
`default_nettype none

module nlc_operand_store (
	input  wire                                          clk,
	input  wire                                          reset,
	input  wire                                          capture_i,
	input  wire                                          issue_en_i,
	input  wire                                          release_i,
	input  wire nlc_pkg::adc_word_t [nlc_pkg::NUM_CH-1:0] x_adc_i,
	input  wire [nlc_pkg::CH_W-1:0]                      ch_idx_i,
	input  wire [nlc_pkg::PASS_W-1:0]                    pass_idx_i,
	input  wire nlc_pkg::nlc_chan_params_t               params_i,
	nlc_mac_if.issuer                                    mac,
	nlc_mac_if.sink                                      res,
	output nlc_pkg::adc_word_t [nlc_pkg::NUM_CH-1:0]     x_lin_o
);
	import nlc_pkg::*;

	adc_word_t         x_q    [NUM_CH];
	nlc_word_t         norm_q [NUM_CH];
	nlc_word_t         acc_q  [NUM_CH];
	nlc_word_t         sample;
	nlc_word_t         a_d;
	nlc_word_t         b_d;
	nlc_word_t         c_d;
	logic [PASS_W-1:0] coef_sel;

	assign sample   = nlc_word_t'(x_q[ch_idx_i]) <<< FRAC_W;  // Integer part of Q15.16
	assign coef_sel = PASS_W'(ORDER) - pass_idx_i;

	always_comb begin
		if (pass_idx_i == '0) begin
			a_d = sample;
			b_d = params_i.recip_stdev;
			c_d = params_i.offset;
		end else begin
			a_d = (pass_idx_i == PASS_W'(1)) ? params_i.coeff[ORDER] : acc_q[ch_idx_i];
			b_d = norm_q[ch_idx_i];
			c_d = params_i.coeff[coef_sel];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mac.op_valid <= 1'b0;
		end else begin
			mac.op_valid <= issue_en_i;
		end
	end

	always_ff @(posedge clk) begin
		mac.op_a   <= a_d;
		mac.op_b   <= b_d;
		mac.op_c   <= c_d;
		mac.op_tag <= ch_idx_i;
		if (capture_i) begin
			for (int i = 0; i < NUM_CH; i++) begin
				x_q[i] <= x_adc_i[i];
			end
		end
		if (res.res_valid) begin
			if (pass_idx_i == '0) begin
				norm_q[res.res_tag] <= res.res;
			end else begin
				acc_q[res.res_tag] <= res.res;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			x_lin_o <= '0;
		end else if (release_i) begin
			for (int i = 0; i < NUM_CH; i++) begin
				x_lin_o[i] <= adc_word_t'(acc_q[i] >>> FRAC_W);  // Drop fraction, keep low bits
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/nlc_top.sv
// Parameters may be written only while idle; a run takes NLC_LATENCY cycles from start to done
`default_nettype none

module nlc_top (
	input  wire                                          clk,
	input  wire                                          reset,
	input  wire                                          wb_cyc_i,
	input  wire                                          wb_stb_i,
	input  wire                                          wb_we_i,
	input  wire [nlc_pkg::ADR_W-1:0]                     wb_adr_i,
	input  wire nlc_pkg::nlc_word_t                      wb_dat_i,
	output wire nlc_pkg::nlc_word_t                      wb_dat_o,
	output wire                                          wb_ack_o,
	input  wire                                          start_i,
	input  wire nlc_pkg::adc_word_t [nlc_pkg::NUM_CH-1:0] x_adc_i,
	output wire                                          busy_o,
	output wire                                          done_o,
	output wire nlc_pkg::adc_word_t [nlc_pkg::NUM_CH-1:0] x_lin_o
);
	import nlc_pkg::*;

	nlc_chan_params_t  params;
	logic              capture;
	logic              count_clr;
	logic              issue_en;
	logic              release_run;
	logic [CH_W-1:0]   ch_idx;
	logic [PASS_W-1:0] pass_idx;
	logic              ch_last;
	logic              pass_last;
	logic              drain_done;

	nlc_mac_if mac_if ();

	nlc_param_bank param_bank_i (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.busy_i   (busy_o),
		.rd_ch_i  (ch_idx),
		.params_o (params)
	);

	nlc_seq_fsm seq_fsm_i (
		.clk          (clk),
		.reset        (reset),
		.start_i      (start_i),
		.ch_last_i    (ch_last),
		.pass_last_i  (pass_last),
		.drain_done_i (drain_done),
		.capture_o    (capture),
		.count_clr_o  (count_clr),
		.issue_en_o   (issue_en),
		.release_o    (release_run),
		.busy_o       (busy_o),
		.done_o       (done_o)
	);

	nlc_step_counter step_counter_i (
		.clk          (clk),
		.reset        (reset),
		.clr_i        (count_clr),
		.issue_en_i   (issue_en),
		.ch_idx_o     (ch_idx),
		.pass_idx_o   (pass_idx),
		.ch_last_o    (ch_last),
		.pass_last_o  (pass_last),
		.drain_done_o (drain_done)
	);

	nlc_mac_pipe mac_pipe_i (
		.clk   (clk),
		.reset (reset),
		.mac   (mac_if.mac)
	);

	nlc_operand_store operand_store_i (
		.clk        (clk),
		.reset      (reset),
		.capture_i  (capture),
		.issue_en_i (issue_en),
		.release_i  (release_run),
		.x_adc_i    (x_adc_i),
		.ch_idx_i   (ch_idx),
		.pass_idx_i (pass_idx),
		.params_i   (params),
		.mac        (mac_if.issuer),
		.res        (mac_if.sink),
		.x_lin_o    (x_lin_o)
	);

endmodule

`default_nettype wire

// File: tests/nlc_clk_gen.sv
// Free-running 20 ns clock; reset is held high over the first three rising edges
`default_nettype none

module nlc_clk_gen (
	output logic clk_o,
	output logic reset_o
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	initial begin
		reset_o = 1'b1;
		repeat (3) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

`default_nettype wire

// File: tests/nlc_chk.sv
// Needs a simulator with bind and concurrent assertions; all properties are off during reset
`default_nettype none

module nlc_chk (
	input wire                     clk,
	input wire                     reset,
	input wire                     wb_cyc_i,
	input wire                     wb_stb_i,
	input wire                     wb_we_i,
	input wire                     wb_ack_i,
	input wire                     busy_i,
	input wire                     done_i,
	input wire nlc_pkg::nlc_state_t state_i
);
	timeunit 1ns;
	timeprecision 1ps;
	import nlc_pkg::*;

	int fail_cnt = 0;

	assert property (@(posedge clk) disable iff (reset) done_i |=> !done_i)
		else begin
			fail_cnt++;
			$error("done_o stayed high for more than one cycle");
		end

	assert property (@(posedge clk) disable iff (reset)
		$rose(wb_ack_i) |-> $past(wb_cyc_i && wb_stb_i))
		else begin
			fail_cnt++;
			$error("wb_ack_o rose without a strobe");
		end

	// Back-pressure, no write completes during a run
	assert property (@(posedge clk) disable iff (reset)
		(wb_cyc_i && wb_stb_i && wb_we_i && busy_i) |=> !wb_ack_i)
		else begin
			fail_cnt++;
			$error("write acknowledged while busy");
		end

	// Accepted start leaves IDLE, done follows NLC_LATENCY cycles after the accepting edge
	assert property (@(posedge clk) disable iff (reset)
		(state_i == IDLE) ##1 (state_i == ISSUE) |-> ##(NLC_LATENCY - 1) done_i)
		else begin
			fail_cnt++;
			$error("done_o not NLC_LATENCY cycles after an accepted start");
		end

endmodule

bind nlc_top nlc_chk chk_i (
	.clk      (clk),
	.reset    (reset),
	.wb_cyc_i (wb_cyc_i),
	.wb_stb_i (wb_stb_i),
	.wb_we_i  (wb_we_i),
	.wb_ack_i (wb_ack_o),
	.busy_i   (busy_o),
	.done_i   (done_o),
	.state_i  (seq_fsm_i.state_q)
);

`default_nettype wire

// File: tests/nlc_tb.sv
// Random parameters may wrap in Q15.16; the model wraps the same way, so results match bit for bit
`default_nettype none

module nlc_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import nlc_pkg::*;

	typedef adc_word_t [NUM_CH-1:0] lin_vec_t;

	localparam int NUM_WORDS   = NUM_CH * FIELDS_PER_CH;
	localparam int RUN_CYC     = NLC_LATENCY + 4;
	localparam int NUM_RUNS    = 7;
	localparam int NUM_XFERS   = 4 * NUM_WORDS + 1;  // Each takes three cycles
	localparam int TIMEOUT_CYC = 2 * (NUM_RUNS * RUN_CYC + NUM_XFERS * 3) + 20;

	logic             clk;
	logic             reset;
	logic             wb_cyc;
	logic             wb_stb;
	logic             wb_we;
	logic [ADR_W-1:0] wb_adr;
	nlc_word_t        wb_dat;
	nlc_word_t        wb_rdat;
	logic             wb_ack;
	logic             start;
	lin_vec_t         x_adc;
	logic             busy;
	logic             done;
	lin_vec_t         x_lin;

	nlc_word_t   shadow [NUM_WORDS];  // What the parameter bank should hold
	lin_vec_t    exp_q [$];
	logic [31:0] rng_state = 32'h70cfeded;
	int          err_cnt;
	int          err_mark;
	int          tests_run;
	int          tests_failed;
	int          runs_done;
	int          cycles;

	nlc_clk_gen clk_gen_i (
		.clk_o   (clk),
		.reset_o (reset)
	);

	nlc_top nlc_top_i (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc_i (wb_cyc),
		.wb_stb_i (wb_stb),
		.wb_we_i  (wb_we),
		.wb_adr_i (wb_adr),
		.wb_dat_i (wb_dat),
		.wb_dat_o (wb_rdat),
		.wb_ack_o (wb_ack),
		.start_i  (start),
		.x_adc_i  (x_adc),
		.busy_o   (busy),
		.done_o   (done),
		.x_lin_o  (x_lin)
	);

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic nlc_word_t random_param();
		logic [31:0] r;
		r = lcg_next();
		return $signed(r[31:13]);  // Within +-4.0
	endfunction

	function automatic lin_vec_t sample_vec();
		lin_vec_t    v;
		logic [31:0] r;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			r = lcg_next();
			v[ch] = $signed(r[31:21]);  // Within +-2^10
		end
		return v;
	endfunction

	// Full product, arithmetic shift by the fraction width, add, keep 32 bits
	function automatic nlc_word_t mac_ref(input nlc_word_t a, input nlc_word_t b,
			input nlc_word_t c);
		longint prod;
		prod = longint'(a) * longint'(b);
		return nlc_word_t'((prod >>> FRAC_W) + longint'(c));
	endfunction

	function automatic lin_vec_t ref_correct(input lin_vec_t x);
		lin_vec_t  y;
		nlc_word_t norm;
		nlc_word_t acc;
		int        base;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			base = ch * FIELDS_PER_CH;
			norm = mac_ref(nlc_word_t'($signed(x[ch])) <<< FRAC_W, shadow[base + FLD_RECIP],
				shadow[base + FLD_OFFSET]);
			acc = shadow[base + FLD_COEF0 + ORDER];
			for (int k = ORDER - 1; k >= 0; k--) begin
				acc = mac_ref(acc, norm, shadow[base + FLD_COEF0 + k]);  // Horner step
			end
			y[ch] = adc_word_t'(acc >>> FRAC_W);
		end
		return y;
	endfunction

	task automatic check_val(input string what, input logic signed [63:0] got,
			input logic signed [63:0] exp);
		if (got !== exp) begin
			$display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic wb_xfer(input logic we, input int adr, input nlc_word_t wdat,
			output nlc_word_t rdat);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= we;
		wb_adr <= ADR_W'(adr);
		wb_dat <= wdat;
		do begin
			@(posedge clk);
		end while (!wb_ack);
		rdat = wb_rdat;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		if (we) begin
			shadow[adr] = wdat;
		end
	endtask

	task automatic pulse_start(input bit expect_run, input lin_vec_t x, input lin_vec_t exp);
		@(posedge clk);
		x_adc <= x;
		start <= 1'b1;
		if (expect_run) begin
			exp_q.push_back(exp);
		end
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_busy();
		do begin
			@(posedge clk);
		end while (!busy);
	endtask

	task automatic wait_done();
		do begin
			@(posedge clk);
		end while (!done);
	endtask

	task automatic finish_test(input string name);
		@(posedge clk);  // Compare process sees the last done first
		tests_run++;
		if (err_cnt != err_mark) begin
			tests_failed++;
		end
		$display("Test %0d %s: %s", tests_run, name, (err_cnt == err_mark) ? "ok" : "mismatch");
		err_mark = err_cnt;
	endtask

	always @(posedge clk) begin : compare_runs
		lin_vec_t exp_vec;
		if (!reset && done) begin
			check_val("busy_o in the done cycle", busy, 0);
			if (exp_q.size() == 0) begin
				$display("Unexpected done_o at %0t with no run started", $time);
				err_cnt++;
			end else begin
				exp_vec = exp_q.pop_front();
				for (int ch = 0; ch < NUM_CH; ch++) begin
					check_val($sformatf("x_lin_o[%0d]", ch), x_lin[ch], exp_vec[ch]);
				end
				runs_done++;
			end
		end
	end

	initial begin : watchdog
		while (cycles < TIMEOUT_CYC) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run not finished after %0d cycles", TIMEOUT_CYC);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		nlc_word_t rd;
		nlc_word_t wdat;
		lin_vec_t  xa;
		int        runs_mark;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		wb_adr = '0;
		wb_dat = '0;
		start  = 1'b0;
		x_adc  = '0;
		wait (reset === 1'b0);
		@(posedge clk);

		check_val("busy_o after reset", busy, 0);
		check_val("done_o after reset", done, 0);
		check_val("wb_ack_o after reset", wb_ack, 0);
		for (int ch = 0; ch < NUM_CH; ch++) begin
			check_val($sformatf("x_lin_o[%0d] after reset", ch), x_lin[ch], 0);
		end
		finish_test("reset values");

		for (int a = 0; a < NUM_WORDS; a++) begin
			wb_xfer(1'b1, a, lcg_next(), rd);
		end
		for (int a = 0; a < NUM_WORDS; a++) begin
			wb_xfer(1'b0, a, '0, rd);
			check_val($sformatf("readback of word %0d", a), rd, shadow[a]);
		end
		finish_test("register readback");

		for (int a = 0; a < NUM_WORDS; a++) begin
			wdat = '0;
			if (a % FIELDS_PER_CH == FLD_RECIP || a % FIELDS_PER_CH == FLD_COEF0 + 1) begin
				wdat = 32'h0001_0000;  // 1.0
			end
			wb_xfer(1'b1, a, wdat, rd);
		end
		xa = sample_vec();
		pulse_start(1'b1, xa, xa);
		wait_done();
		finish_test("identity parameters");

		for (int a = 0; a < NUM_WORDS; a++) begin
			wb_xfer(1'b1, a, random_param(), rd);
		end
		repeat (2) begin
			xa = sample_vec();
			pulse_start(1'b1, xa, ref_correct(xa));
			wait_done();
		end
		finish_test("random parameters");

		xa = sample_vec();
		pulse_start(1'b1, xa, ref_correct(xa));
		wait_busy();
		pulse_start(1'b0, sample_vec(), '0);  // Arrives mid-run
		wait_done();
		xa = sample_vec();
		pulse_start(1'b1, xa, ref_correct(xa));
		wait_done();
		finish_test("back-to-back runs");

		xa = sample_vec();
		pulse_start(1'b1, xa, ref_correct(xa));
		wait_busy();
		runs_mark = runs_done;
		wdat = shadow[5 * FIELDS_PER_CH + FLD_COEF0] + 32'h0003_0000;
		wb_xfer(1'b1, 5 * FIELDS_PER_CH + FLD_COEF0, wdat, rd);
		check_val("runs finished before the held write was acked", runs_done - runs_mark, 1);
		pulse_start(1'b1, xa, ref_correct(xa));
		wait_done();
		finish_test("write held while busy");

		if (exp_q.size() != 0) begin
			$display("Missing done_o for %0d started runs", exp_q.size());
			err_cnt++;
		end
		if (nlc_top_i.chk_i.fail_cnt != 0) begin
			$display("Checker assertions failed %0d times", nlc_top_i.chk_i.fail_cnt);
			err_cnt += nlc_top_i.chk_i.fail_cnt;
		end
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
logic/nlc_pkg.sv
logic/nlc_mac_if.sv
logic/nlc_param_bank.sv
logic/nlc_seq_fsm.sv
logic/nlc_step_counter.sv
logic/nlc_mac_pipe.sv
logic/nlc_operand_store.sv
logic/nlc_top.sv
tests/nlc_clk_gen.sv
tests/nlc_chk.sv
tests/nlc_tb.sv

// File: Bender.yml
package:
  name: nlc

sources:
  - logic/nlc_pkg.sv
  - logic/nlc_mac_if.sv
  - logic/nlc_param_bank.sv
  - logic/nlc_seq_fsm.sv
  - logic/nlc_step_counter.sv
  - logic/nlc_mac_pipe.sv
  - logic/nlc_operand_store.sv
  - logic/nlc_top.sv
  - target: test
    files:
      - tests/nlc_clk_gen.sv
      - tests/nlc_chk.sv
      - tests/nlc_tb.sv
